// ==== verilog/cache_types_pkg.sv ====
// cache geometry localparams, address union, line, byte-enable and metadata types
`default_nettype none

package cache_types_pkg;

    // two-way set-associative, 8 sets of 32-byte lines
    localparam int num_sets    = 8;
    localparam int num_ways    = 2;
    localparam int line_bytes  = 32;
    localparam int tag_bits    = 24;
    localparam int set_bits    = 3;
    localparam int offset_bits = 5;

    // one full cache line, word 0 in the low bits
    typedef logic [8*line_bytes-1:0] cacheline_t;

    // one enable per byte of a line
    typedef logic [line_bytes-1:0] byte_en_t;

    // field view of a 32-bit byte address
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [set_bits-1:0]    set;
        logic [offset_bits-1:0] offset;
    } cache_addr_fields_t;

    // the same address seen as a plain word or split into fields
    typedef union packed {
        logic [31:0]        word;
        cache_addr_fields_t f;
    } cache_addr_u;

    // per-way metadata entry of one set
    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [tag_bits-1:0] tag;
    } way_meta_t;

endpackage : cache_types_pkg

`default_nettype wire

// ==== verilog/cache_ctrl_pkg.sv ====
// mux-select enums and the control/datapath status and command structs
`default_nettype none

package cache_ctrl_pkg;

    typedef enum logic {addrmux_cpu, addrmux_victim} addrmux_sel_t;
    typedef enum logic {datamux_mem, datamux_cpu} datamux_sel_t;
    typedef enum logic {benmux_all, benmux_cpu} benmux_sel_t;
    typedef enum logic {waymux_hit, waymux_lru} waymux_sel_t;

    // commands from the FSM to the arrays and muxes
    typedef struct packed {
        addrmux_sel_t addrmux_sel;
        datamux_sel_t datamux_sel;
        benmux_sel_t  benmux_sel;
        waymux_sel_t  waymux_sel;
        logic         data_write;
        logic         tag_write;
        logic         valid_write;
        logic         dirty_write;
        logic         dirty_value;
        logic         lru_write;
    } ctrl_to_dp_t;

    // lookup results back to the FSM
    typedef struct packed {
        logic hit;
        logic hit_way;
        logic victim_dirty;
    } dp_to_ctrl_t;

endpackage : cache_ctrl_pkg

`default_nettype wire

// ==== verilog/bus_adapter.sv ====
// CPU word and byte enables to line width and the addressed word out of a line
`timescale 1ns/100ps
`default_nettype none

module bus_adapter
    import cache_types_pkg::*;
(
    input  logic [31:0] mem_wdata,
    input  logic [3:0]  mem_byte_enable,
    input  cache_addr_u address,
    input  cacheline_t  mem_rdata256,
    output cacheline_t  mem_wdata256,
    output byte_en_t    mem_byte_enable256,
    output logic [31:0] mem_rdata
);

    // word slot inside the line
    logic [2:0] word_sel;

    assign word_sel = address.f.offset[4:2];

    // the word goes to every slot and the enables pick the real one
    assign mem_wdata256 = {(line_bytes/4){mem_wdata}};

    // four enables shifted to the addressed word with zeros elsewhere
    assign mem_byte_enable256 = byte_en_t'(mem_byte_enable) << {word_sel, 2'b00};

    assign mem_rdata = mem_rdata256[{word_sel, 5'b00000} +: 32];

endmodule : bus_adapter

`default_nettype wire

// ==== verilog/cache_datapath.sv ====
// tag, valid, dirty, LRU and data arrays, hit logic and muxes
`timescale 1ns/100ps
`default_nettype none

module cache_datapath
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  cache_addr_u cpu_address,
    input  cacheline_t  cpu_wdata,
    input  byte_en_t    cpu_byte_enable,
    input  cacheline_t  ca_rdata,
    input  ctrl_to_dp_t ctrl,
    output cacheline_t  cpu_rdata,
    output cacheline_t  ca_wdata,
    output cache_addr_u ca_address,
    output dp_to_ctrl_t status
);

    // arrays as flops with combinational read
    way_meta_t  meta [num_ways][num_sets];
    cacheline_t data [num_ways][num_sets];
    logic [num_sets-1:0] lru;

    logic [set_bits-1:0] set_idx;
    logic [tag_bits-1:0] addr_tag;
    logic [num_ways-1:0] way_hit;
    logic                hit_way;
    logic                victim_way;
    logic                sel_way;
    cacheline_t          sel_line;
    cacheline_t          src_line;
    byte_en_t            src_ben;
    cacheline_t          new_line;
    cache_addr_u         victim_addr;

    assign set_idx  = cpu_address.f.set;
    assign addr_tag = cpu_address.f.tag;

    // tag compare on both ways
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = meta[w][set_idx].valid && (meta[w][set_idx].tag == addr_tag);
        end
    end

    assign hit_way    = way_hit[1];
    // lru bit names the way to replace next
    assign victim_way = lru[set_idx];
    assign sel_way    = (ctrl.waymux_sel == waymux_hit) ? hit_way : victim_way;
    assign sel_line   = data[sel_way][set_idx];

    assign status.hit          = |way_hit;
    assign status.hit_way      = hit_way;
    assign status.victim_dirty = meta[victim_way][set_idx].valid &&
                                 meta[victim_way][set_idx].dirty;

    // read data to the CPU and write-back data to memory share the way mux
    assign cpu_rdata = sel_line;
    assign ca_wdata  = sel_line;

    // victim line address rebuilt from its stored tag
    always_comb begin
        victim_addr.f.tag    = meta[victim_way][set_idx].tag;
        victim_addr.f.set    = set_idx;
        victim_addr.f.offset = '0;
    end

    always_comb begin
        if (ctrl.addrmux_sel == addrmux_victim) begin
            ca_address = victim_addr;
        end else begin
            ca_address.word = {cpu_address.word[31:offset_bits], {offset_bits{1'b0}}};
        end
    end

    // fill line or CPU line merged over the old contents byte by byte
    assign src_line = (ctrl.datamux_sel == datamux_mem) ? ca_rdata : cpu_wdata;
    assign src_ben  = (ctrl.benmux_sel == benmux_all) ? '1 : cpu_byte_enable;

    always_comb begin
        for (int i = 0; i < line_bytes; i++) begin
            new_line[8*i +: 8] = src_ben[i] ? src_line[8*i +: 8] : sel_line[8*i +: 8];
        end
    end

    // metadata and lru updates
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_ways; w++) begin
                for (int s = 0; s < num_sets; s++) begin
                    meta[w][s].valid <= 1'b0;
                    meta[w][s].dirty <= 1'b0;
                end
            end
            lru <= '0;
        end else begin
            if (ctrl.valid_write) begin
                meta[sel_way][set_idx].valid <= 1'b1;
            end
            if (ctrl.tag_write) begin
                meta[sel_way][set_idx].tag <= addr_tag;
            end
            if (ctrl.dirty_write) begin
                meta[sel_way][set_idx].dirty <= ctrl.dirty_value;
            end
            // point at the other way after a use
            if (ctrl.lru_write) begin
                lru[set_idx] <= ~sel_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.data_write) begin
            data[sel_way][set_idx] <= new_line;
        end
    end

    // a tag is only ever placed once per fill, so two ways cannot match
    a_one_way_hit: assert property (@(posedge clk) disable iff (reset)
        !(way_hit[0] && way_hit[1]));

    a_tag_with_valid: assert property (@(posedge clk) disable iff (reset)
        ctrl.tag_write |-> ctrl.valid_write);

endmodule : cache_datapath

`default_nettype wire

// ==== verilog/cache_control.sv ====
// FSM sequencing hit, victim write-back and line fill
`timescale 1ns/100ps
`default_nettype none

module cache_control
    import cache_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        mem_read,
    input  logic        mem_write,
    input  logic        pmem_resp,
    input  dp_to_ctrl_t status,
    output logic        mem_resp,
    output logic        pmem_read,
    output logic        pmem_write,
    output ctrl_to_dp_t ctrl
);

    typedef enum logic [1:0] {
        s_check,
        s_writeback,
        s_fill
    } state_t;

    state_t state;
    state_t next_state;
    logic   request;

    assign request = mem_read || mem_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_check;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;

        // default selects serve a CPU access to the hit way
        ctrl.addrmux_sel = addrmux_cpu;
        ctrl.datamux_sel = datamux_cpu;
        ctrl.benmux_sel  = benmux_cpu;
        ctrl.waymux_sel  = waymux_hit;
        ctrl.data_write  = 1'b0;
        ctrl.tag_write   = 1'b0;
        ctrl.valid_write = 1'b0;
        ctrl.dirty_write = 1'b0;
        ctrl.dirty_value = 1'b0;
        ctrl.lru_write   = 1'b0;

        unique case (state)
            s_check: begin
                if (request) begin
                    if (status.hit) begin
                        // answer in the same cycle and update at this edge
                        mem_resp       = 1'b1;
                        ctrl.lru_write = 1'b1;
                        if (mem_write) begin
                            ctrl.data_write  = 1'b1;
                            ctrl.dirty_write = 1'b1;
                            ctrl.dirty_value = 1'b1;
                        end
                    end else if (status.victim_dirty) begin
                        next_state = s_writeback;
                    end else begin
                        next_state = s_fill;
                    end
                end
            end

            s_writeback: begin
                pmem_write       = 1'b1;
                ctrl.addrmux_sel = addrmux_victim;
                ctrl.waymux_sel  = waymux_lru;
                if (pmem_resp) begin
                    next_state = s_fill;
                end
            end

            s_fill: begin
                pmem_read        = 1'b1;
                ctrl.waymux_sel  = waymux_lru;
                ctrl.datamux_sel = datamux_mem;
                ctrl.benmux_sel  = benmux_all;
                if (pmem_resp) begin
                    // new line lands clean and valid under the CPU tag
                    ctrl.data_write  = 1'b1;
                    ctrl.tag_write   = 1'b1;
                    ctrl.valid_write = 1'b1;
                    ctrl.dirty_write = 1'b1;
                    next_state       = s_check;
                end
            end

            default: begin
                next_state = s_check;
            end
        endcase
    end

    a_cpu_one_op: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write));

    a_pmem_one_op: assert property (@(posedge clk) disable iff (reset)
        !(pmem_read && pmem_write));

    a_resp_with_req: assert property (@(posedge clk) disable iff (reset)
        mem_resp |-> request);

endmodule : cache_control

`default_nettype wire

// ==== verilog/cache.sv ====
// top level joining control FSM, datapath and bus adapter
`timescale 1ns/100ps
`default_nettype none

module cache
    import cache_types_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    // CPU side
    input  logic [31:0]  mem_address,
    input  logic [31:0]  mem_wdata,
    input  logic         mem_read,
    input  logic         mem_write,
    input  logic [3:0]   mem_byte_enable,
    output logic [31:0]  mem_rdata,
    output logic         mem_resp,
    // line memory side
    input  logic [255:0] pmem_rdata,
    input  logic         pmem_resp,
    output logic [255:0] pmem_wdata,
    output logic [31:0]  pmem_address,
    output logic         pmem_read,
    output logic         pmem_write
);

    cache_addr_u cpu_address;
    cacheline_t  cpu_wdata;
    byte_en_t    cpu_byte_enable;
    cacheline_t  cpu_rdata;
    cache_addr_u ca_address;
    ctrl_to_dp_t ctrl;
    dp_to_ctrl_t status;

    assign cpu_address.word = mem_address;
    assign pmem_address     = ca_address.word;

    cache_control control (
        .clk        (clk),
        .reset      (reset),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .status     (status),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .ctrl       (ctrl)
    );

    cache_datapath datapath (
        .clk             (clk),
        .reset           (reset),
        .cpu_address     (cpu_address),
        .cpu_wdata       (cpu_wdata),
        .cpu_byte_enable (cpu_byte_enable),
        .ca_rdata        (pmem_rdata),
        .ctrl            (ctrl),
        .cpu_rdata       (cpu_rdata),
        .ca_wdata        (pmem_wdata),
        .ca_address      (ca_address),
        .status          (status)
    );

    bus_adapter bus_adapter (
        .mem_wdata          (mem_wdata),
        .mem_byte_enable    (mem_byte_enable),
        .address            (cpu_address),
        .mem_rdata256       (cpu_rdata),
        .mem_wdata256       (cpu_wdata),
        .mem_byte_enable256 (cpu_byte_enable),
        .mem_rdata          (mem_rdata)
    );

endmodule : cache

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
// testbench clock and synchronous reset generator
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for three rising edges and released just after the third
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== verif/cache_tb.sv ====
// line memory model, LFSR, directed cache tests, timeout and summary
`timescale 1ns/100ps
`default_nettype none

module cache_tb
    import cache_types_pkg::*;
();

    localparam logic [31:0] fill_xor      = 32'h5a3c_0000;
    localparam int          max_mem_delay = 3;
    // check cycle, write-back and fill at the longest delay, then the hit
    localparam int          miss_cycles   = 2 * (max_mem_delay + 2) + 2;
    localparam int          num_requests  = 64;
    localparam int          timeout_limit = num_requests * (miss_cycles + 2) + 100;

    logic         clk;
    logic         reset;
    logic [31:0]  mem_address;
    logic [31:0]  mem_wdata;
    logic         mem_read;
    logic         mem_write;
    logic [3:0]   mem_byte_enable;
    logic [31:0]  mem_rdata;
    logic         mem_resp;
    logic [255:0] pmem_rdata;
    logic         pmem_resp;
    logic [255:0] pmem_wdata;
    logic [31:0]  pmem_address;
    logic         pmem_read;
    logic         pmem_write;

    // line memory seen by the cache and word model seen by the CPU
    cacheline_t  line_mem [256];
    logic [31:0] ref_mem [2048];

    logic [31:0] lfsr_state    = 32'h8c3eb22f;
    int          read_count    = 0;
    int          write_count   = 0;
    int          reads_at_wr   = 0;
    int          cycle_count   = 0;
    int          test_errors   = 0;
    int          total_errors  = 0;
    int          tests_run     = 0;
    int          failed_tests  = 0;
    logic [31:0] last_wr_addr  = '0;
    cacheline_t  last_wr_line  = '0;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    cache u_dut (
        .clk             (clk),
        .reset           (reset),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .pmem_rdata      (pmem_rdata),
        .pmem_resp       (pmem_resp),
        .pmem_wdata      (pmem_wdata),
        .pmem_address    (pmem_address),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] make_addr(input int tag, input int set_idx, input int word);
        cache_addr_u a;
        a.f.tag    = tag_bits'(tag);
        a.f.set    = set_bits'(set_idx);
        a.f.offset = offset_bits'(word * 4);
        return a.word;
    endfunction

    // each word starts as its own byte address xor a constant
    task automatic init_memories();
        for (int i = 0; i < 2048; i++) begin
            ref_mem[i] = (i * 4) ^ fill_xor;
            line_mem[i / 8][32 * (i % 8) +: 32] = (i * 4) ^ fill_xor;
        end
    endtask

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] wdata,
                                        input logic [3:0] be);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                ref_mem[addr[12:2]][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endfunction

    function automatic cacheline_t model_line(input logic [31:0] addr);
        cacheline_t l;
        for (int j = 0; j < 8; j++) begin
            l[32*j +: 32] = ref_mem[{addr[12:5], 3'(j)}];
        end
        return l;
    endfunction

    // line memory answering after 0 to max_mem_delay extra cycles
    initial begin : line_memory
        logic [31:0] delay;
        logic [7:0]  idx;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(negedge clk);
            if (!reset && (pmem_read || pmem_write)) begin
                take_bits(2, delay);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1;
                idx = pmem_address[12:5];
                if (pmem_write) begin
                    line_mem[idx] = pmem_wdata;
                    last_wr_addr  = pmem_address;
                    last_wr_line  = pmem_wdata;
                    reads_at_wr   = read_count;
                    write_count++;
                end else begin
                    pmem_rdata = line_mem[idx];
                    read_count++;
                end
                pmem_resp = 1'b1;
                @(posedge clk);
                #1;
                pmem_resp = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR %0d ns %s expected %h actual %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        assert (act == exp) else begin
            $display("ERROR %0d ns %s expected %0d actual %0d", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_line(input logic [31:0] addr, input cacheline_t act);
        cacheline_t exp;
        exp = model_line(addr);
        assert (act === exp) else begin
            $display("ERROR %0d ns pmem_wdata expected %h actual %h", $time, exp, act);
            test_errors++;
        end
    endtask

    // mem_resp is sampled mid cycle once the combinational hit has settled
    task automatic wait_resp();
        @(negedge clk);
        while (!mem_resp) begin
            @(negedge clk);
        end
    endtask

    task automatic cpu_read(input logic [31:0] addr, output logic [31:0] data);
        mem_address = addr;
        mem_read    = 1'b1;
        wait_resp();
        data = mem_rdata;
        @(posedge clk);
        #1;
        mem_read = 1'b0;
    endtask

    task automatic cpu_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] be);
        mem_address     = addr;
        mem_wdata       = wdata;
        mem_byte_enable = be;
        mem_write       = 1'b1;
        wait_resp();
        @(posedge clk);
        #1;
        mem_write = 1'b0;
        model_write(addr, wdata, be);
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [31:0] data;
        cpu_read(addr, data);
        check_value("mem_rdata", ref_mem[addr[12:2]], data);
    endtask

    task automatic start_test();
        test_errors = 0;
        tests_run++;
    endtask

    task automatic finish_test(input string name);
        $display("test %-18s %s", name, (test_errors == 0) ? "ok" : "failed");
        total_errors += test_errors;
        if (test_errors != 0) begin
            failed_tests++;
        end
    endtask

    task automatic test_read_miss();
        int r0;
        int w0;
        start_test();
        r0 = read_count;
        w0 = write_count;
        read_check(make_addr(1, 2, 3));
        check_count("line reads", r0 + 1, read_count);
        check_count("line writes", w0, write_count);
        finish_test("read miss");
    endtask

    task automatic test_read_hit();
        int r0;
        int w0;
        start_test();
        r0 = read_count;
        w0 = write_count;
        read_check(make_addr(1, 2, 6));
        check_count("line reads", r0, read_count);
        check_count("line writes", w0, write_count);
        finish_test("read hit");
    endtask

    task automatic test_write_merge();
        int r0;
        int w0;
        start_test();
        r0 = read_count;
        w0 = write_count;
        cpu_write(make_addr(1, 2, 3), 32'hdead_beef, 4'b0101);
        cpu_write(make_addr(1, 2, 6), 32'h7700_0000, 4'b1000);
        cpu_write(make_addr(1, 2, 3), 32'h0000_c300, 4'b0010);
        read_check(make_addr(1, 2, 3));
        read_check(make_addr(1, 2, 6));
        check_count("line reads", r0, read_count);
        check_count("line writes", w0, write_count);
        finish_test("write merge");
    endtask

    task automatic test_dirty_eviction();
        int r0;
        int w0;
        start_test();
        read_check(make_addr(2, 5, 0));
        cpu_write(make_addr(3, 5, 4), 32'hcafe_f00d, 4'b1111);
        cpu_write(make_addr(3, 5, 1), 32'h0000_a500, 4'b0010);
        // touch the first tag so the second becomes the victim
        read_check(make_addr(2, 5, 7));
        r0 = read_count;
        w0 = write_count;
        read_check(make_addr(4, 5, 2));
        check_count("line writes", w0 + 1, write_count);
        check_count("line reads", r0 + 1, read_count);
        check_count("line reads before write-back", r0, reads_at_wr);
        check_value("pmem_address", make_addr(3, 5, 0), last_wr_addr);
        check_line(make_addr(3, 5, 0), last_wr_line);
        // refetch of the written-back line from memory
        read_check(make_addr(3, 5, 1));
        read_check(make_addr(3, 5, 4));
        finish_test("dirty eviction");
    endtask

    task automatic test_clean_eviction();
        int r0;
        int w0;
        start_test();
        read_check(make_addr(5, 7, 0));
        read_check(make_addr(6, 7, 1));
        r0 = read_count;
        w0 = write_count;
        read_check(make_addr(7, 7, 2));
        check_count("line reads", r0 + 1, read_count);
        check_count("line writes", w0, write_count);
        r0 = read_count;
        read_check(make_addr(5, 7, 3));
        check_count("line reads on refill", r0 + 1, read_count);
        check_count("line writes on refill", w0, write_count);
        finish_test("clean eviction");
    endtask

    // three tags over two sets, so dirty and clean evictions mix
    task automatic test_random_pattern();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] wdata;
        int          tag;
        int          set_idx;
        int          word;
        start_test();
        for (int n = 0; n < 40; n++) begin
            take_bits(2, r);
            tag = 8 + (r % 3);
            take_bits(1, r);
            set_idx = r[0] ? 3 : 1;
            take_bits(3, r);
            word = r;
            addr = make_addr(tag, set_idx, word);
            take_bits(1, r);
            if (r[0]) begin
                take_bits(4, r);
                take_bits(32, wdata);
                cpu_write(addr, wdata, r[3:0]);
            end else begin
                read_check(addr);
            end
        end
        finish_test("random pattern");
    endtask

    initial begin : main
        mem_address     = '0;
        mem_wdata       = '0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_byte_enable = 4'hf;
        init_memories();
        wait (reset === 1'b0);
        @(posedge clk);
        #1;

        test_read_miss();
        test_read_hit();
        test_write_merge();
        test_dirty_eviction();
        test_clean_eviction();
        test_random_pattern();

        $display("tests %0d, failed %0d, check errors %0d, line reads %0d, line writes %0d",
                 tests_run, failed_tests, total_errors, read_count, write_count);
        if (total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : cache_tb

`default_nettype wire

// ==== cache.f ====
verilog/cache_types_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/bus_adapter.sv
verilog/cache_datapath.sv
verilog/cache_control.sv
verilog/cache.sv
verif/tb_clock_gen.sv
verif/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache

sources:
  # packages first, then the RTL blocks and the top level
  - verilog/cache_types_pkg.sv
  - verilog/cache_ctrl_pkg.sv
  - verilog/bus_adapter.sv
  - verilog/cache_datapath.sv
  - verilog/cache_control.sv
  - verilog/cache.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/cache_tb.sv
